// File: source/cache_pkg.sv
package cache_pkg;

	// Data word and word address widths
	localparam int WORD_BITS = 32;
	localparam int ADDR_BITS = 32;

	// Destination register index
	localparam int RD_BITS = 5;

	// Warp number carried with every request
	localparam int WARP_BITS = 4;

	// Per-lane memory operation
	typedef enum logic [0:0] {
		MEM_LOAD  = 1'b0,
		MEM_STORE = 1'b1
	} mem_op_t;

	// Four-phase handshake progress
	// HS_IDLE waits for work, HS_ACK holds the strobe high,
	// HS_WAIT_DROP lets the far side finish its half of the exchange
	typedef enum logic [1:0] {
		HS_IDLE      = 2'd0,
		HS_ACK       = 2'd1,
		HS_WAIT_DROP = 2'd2
	} hs_state_t;

endpackage

// File: source/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] in_data,
	input  logic             pop,
	output logic [WIDTH-1:0] out_data,
	output logic             empty,
	output logic             full
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    entries [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;
	logic                push_ok;
	logic                pop_ok;

	assign push_ok = push && !full;
	assign pop_ok  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == CNT_BITS'(DEPTH));
	assign out_data = entries[rd_ptr];

	// Pointers wrap at DEPTH so any depth works
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push_ok && !pop_ok) begin
				count <= count + 1'b1;
			end else if (pop_ok && !push_ok) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok) begin
			entries[wr_ptr] <= in_data;
		end
	end

endmodule

// File: source/core_req_accept.sv
`timescale 1ns/1ps

module core_req_accept #(
	parameter int NUM_LANES = 4
) (
	input  logic                                            clk,
	input  logic                                            reset,

	// Core side
	input  logic                                            core_req,
	output logic                                            core_ack,
	input  logic [NUM_LANES-1:0]                            lane_valid,
	input  logic [NUM_LANES-1:0]                            lane_op,
	input  logic [NUM_LANES-1:0][cache_pkg::ADDR_BITS-1:0]  lane_addr,
	input  logic [NUM_LANES-1:0][cache_pkg::WORD_BITS-1:0]  lane_wdata,
	input  logic [cache_pkg::RD_BITS-1:0]                   rd,
	input  logic [cache_pkg::WARP_BITS-1:0]                 warp,

	// Request queue side
	input  logic                                            full,
	output logic                                            push,
	output logic [NUM_LANES-1:0]                            push_lane_valid,
	output logic [NUM_LANES-1:0]                            push_lane_op,
	output logic [NUM_LANES-1:0][cache_pkg::ADDR_BITS-1:0]  push_lane_addr,
	output logic [NUM_LANES-1:0][cache_pkg::WORD_BITS-1:0]  push_lane_wdata,
	output logic [cache_pkg::RD_BITS-1:0]                   push_rd,
	output logic [cache_pkg::WARP_BITS-1:0]                 push_warp
);

	import cache_pkg::*;

	hs_state_t state;

	// Store the request in the one idle cycle where space is free
	assign push     = (state == HS_IDLE) && core_req && !full;
	assign core_ack = (state == HS_ACK);

	// The core keeps the fields stable until it sees core_ack
	assign push_lane_valid = lane_valid;
	assign push_lane_op    = lane_op;
	assign push_lane_addr  = lane_addr;
	assign push_lane_wdata = lane_wdata;
	assign push_rd         = rd;
	assign push_warp       = warp;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= HS_IDLE;
		end else begin
			case (state)
				HS_IDLE: begin
					if (push) begin
						state <= HS_ACK;
					end
				end
				HS_ACK: begin
					if (!core_req) begin
						state <= HS_WAIT_DROP;
					end
				end
				// core_ack is already low here, one spare cycle before the next request
				HS_WAIT_DROP: begin
					state <= HS_IDLE;
				end
				default: begin
					state <= HS_IDLE;
				end
			endcase
		end
	end

endmodule

// File: source/cache_req_queue.sv
`timescale 1ns/1ps

module cache_req_queue #(
	parameter int  NUM_LANES  = 4,
	parameter int  REQQ_DEPTH = 4,
	localparam int TID_BITS   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                                            clk,
	input  logic                                            reset,

	// Enqueue side
	input  logic                                            push,
	input  logic [NUM_LANES-1:0]                            lane_valid,
	input  logic [NUM_LANES-1:0]                            lane_op,
	input  logic [NUM_LANES-1:0][cache_pkg::ADDR_BITS-1:0]  lane_addr,
	input  logic [NUM_LANES-1:0][cache_pkg::WORD_BITS-1:0]  lane_wdata,
	input  logic [cache_pkg::RD_BITS-1:0]                   rd,
	input  logic [cache_pkg::WARP_BITS-1:0]                 warp,
	output logic                                            full,

	// Single-lane issue to the bank
	output logic                                            issue_valid,
	output logic [TID_BITS-1:0]                             issue_tid,
	output cache_pkg::mem_op_t                              issue_op,
	output logic [cache_pkg::ADDR_BITS-1:0]                 issue_addr,
	output logic [cache_pkg::WORD_BITS-1:0]                 issue_wdata,
	output logic [cache_pkg::RD_BITS-1:0]                   issue_rd,
	output logic [cache_pkg::WARP_BITS-1:0]                 issue_warp,
	input  logic                                            issue_ready
);

	import cache_pkg::*;

	localparam int FIFO_BITS = NUM_LANES * (2 + ADDR_BITS + WORD_BITS) + RD_BITS + WARP_BITS;

	logic [NUM_LANES-1:0]                 head_valid;
	logic [NUM_LANES-1:0]                 head_op;
	logic [NUM_LANES-1:0][ADDR_BITS-1:0]  head_addr;
	logic [NUM_LANES-1:0][WORD_BITS-1:0]  head_wdata;
	logic [RD_BITS-1:0]                   head_rd;
	logic [WARP_BITS-1:0]                 head_warp;
	logic                                 fifo_empty;

	// Lane register, the request currently being serialized
	logic [NUM_LANES-1:0]                 use_valid;
	logic [NUM_LANES-1:0]                 use_op;
	logic [NUM_LANES-1:0][ADDR_BITS-1:0]  use_addr;
	logic [NUM_LANES-1:0][WORD_BITS-1:0]  use_wdata;
	logic [RD_BITS-1:0]                   use_rd;
	logic [WARP_BITS-1:0]                 use_warp;

	logic                                 use_empty;
	logic                                 pop;
	logic [TID_BITS-1:0]                  sel_tid;

	req_fifo #(
		.WIDTH (FIFO_BITS),
		.DEPTH (REQQ_DEPTH)
	) reqq_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (push),
		.in_data  ({lane_valid, lane_op, lane_addr, lane_wdata, rd, warp}),
		.pop      (pop),
		.out_data ({head_valid, head_op, head_addr, head_wdata, head_rd, head_warp}),
		.empty    (fifo_empty),
		.full     (full)
	);

	assign use_empty = ~|use_valid;
	assign pop       = use_empty && !fifo_empty;

	// Lowest valid lane wins
	always_comb begin
		sel_tid = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (use_valid[i]) begin
				sel_tid = TID_BITS'(i);
			end
		end
	end

	assign issue_valid = !use_empty;
	assign issue_tid   = sel_tid;
	assign issue_op    = mem_op_t'(use_op[sel_tid]);
	assign issue_addr  = use_addr[sel_tid];
	assign issue_wdata = use_wdata[sel_tid];
	assign issue_rd    = use_rd;
	assign issue_warp  = use_warp;

	// An all-zero lane_valid loads as an empty register and is gone next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			use_valid <= '0;
		end else if (pop) begin
			use_valid <= head_valid;
		end else if (issue_valid && issue_ready) begin
			use_valid[sel_tid] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			use_op    <= head_op;
			use_addr  <= head_addr;
			use_wdata <= head_wdata;
			use_rd    <= head_rd;
			use_warp  <= head_warp;
		end
	end

endmodule

// File: source/bank_data_store.sv
`timescale 1ns/1ps

module bank_data_store #(
	parameter int BANK_WORDS = 64,
	parameter int TID_BITS   = 2
) (
	input  logic                             clk,
	input  logic                             reset,

	// Access from the request queue
	input  logic                             issue_valid,
	input  logic [TID_BITS-1:0]              issue_tid,
	input  cache_pkg::mem_op_t               issue_op,
	input  logic [cache_pkg::ADDR_BITS-1:0]  issue_addr,
	input  logic [cache_pkg::WORD_BITS-1:0]  issue_wdata,
	input  logic [cache_pkg::RD_BITS-1:0]    issue_rd,
	input  logic [cache_pkg::WARP_BITS-1:0]  issue_warp,
	output logic                             issue_ready,

	// Load results
	output logic                             load_valid,
	output logic [TID_BITS-1:0]              load_tid,
	output logic [cache_pkg::WORD_BITS-1:0]  load_data,
	output logic [cache_pkg::RD_BITS-1:0]    load_rd,
	output logic [cache_pkg::WARP_BITS-1:0]  load_warp,
	input  logic                             load_ready
);

	import cache_pkg::*;

	localparam int IDX_BITS = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

	logic [WORD_BITS-1:0] mem [BANK_WORDS];
	logic [IDX_BITS-1:0]  idx;
	logic                 accept;

	// Access register, one entry
	logic                 out_valid;
	mem_op_t              out_op;
	logic                 out_load;

	assign idx = IDX_BITS'(issue_addr % BANK_WORDS);

	// A held store never blocks, only an unclaimed load does
	assign out_load    = out_valid && (out_op == MEM_LOAD);
	assign issue_ready = !out_load || load_ready;
	assign accept      = issue_valid && issue_ready;

	assign load_valid = out_load;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (issue_ready) begin
			out_valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_op    <= issue_op;
			load_tid  <= issue_tid;
			load_data <= mem[idx];
			load_rd   <= issue_rd;
			load_warp <= issue_warp;
		end
	end

	// Write lands at the accept edge; a later load reads the new word
	always_ff @(posedge clk) begin
		if (accept && (issue_op == MEM_STORE)) begin
			mem[idx] <= issue_wdata;
		end
	end

endmodule

// File: source/core_rsp_send.sv
`timescale 1ns/1ps

module core_rsp_send #(
	parameter int  NUM_LANES = 4,
	localparam int TID_BITS  = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                             clk,
	input  logic                             reset,

	// From the bank
	input  logic                             load_valid,
	input  logic [TID_BITS-1:0]              load_tid,
	input  logic [cache_pkg::WORD_BITS-1:0]  load_data,
	input  logic [cache_pkg::RD_BITS-1:0]    load_rd,
	input  logic [cache_pkg::WARP_BITS-1:0]  load_warp,
	output logic                             load_ready,

	// Core response handshake
	output logic                             rsp_req,
	output logic [TID_BITS-1:0]              rsp_tid,
	output logic [cache_pkg::WORD_BITS-1:0]  rsp_data,
	output logic [cache_pkg::RD_BITS-1:0]    rsp_rd,
	output logic [cache_pkg::WARP_BITS-1:0]  rsp_warp,
	input  logic                             rsp_ack
);

	import cache_pkg::*;

	hs_state_t state;
	logic      buf_full;

	assign load_ready = (state == HS_IDLE) && !buf_full;
	assign rsp_req    = (state == HS_ACK);

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= HS_IDLE;
			buf_full <= 1'b0;
		end else begin
			case (state)
				HS_IDLE: begin
					if (load_valid && load_ready) begin
						buf_full <= 1'b1;
					end else if (buf_full && !rsp_ack) begin
						state <= HS_ACK;
					end
				end
				HS_ACK: begin
					if (rsp_ack) begin
						state <= HS_WAIT_DROP;
					end
				end
				// Buffer stays put until the core lets go of rsp_ack
				HS_WAIT_DROP: begin
					if (!rsp_ack) begin
						state    <= HS_IDLE;
						buf_full <= 1'b0;
					end
				end
				default: begin
					state <= HS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_valid && load_ready) begin
			rsp_tid  <= load_tid;
			rsp_data <= load_data;
			rsp_rd   <= load_rd;
			rsp_warp <= load_warp;
		end
	end

endmodule

// File: source/cache_bank_top.sv
`timescale 1ns/1ps

module cache_bank_top #(
	parameter int  NUM_LANES  = 4,
	parameter int  REQQ_DEPTH = 4,
	parameter int  BANK_WORDS = 64,
	localparam int TID_BITS   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                                            clk,
	input  logic                                            reset,

	// Core request, four-phase
	input  logic                                            core_req,
	output logic                                            core_ack,
	input  logic [NUM_LANES-1:0]                            lane_valid,
	input  logic [NUM_LANES-1:0]                            lane_op,
	input  logic [NUM_LANES-1:0][cache_pkg::ADDR_BITS-1:0]  lane_addr,
	input  logic [NUM_LANES-1:0][cache_pkg::WORD_BITS-1:0]  lane_wdata,
	input  logic [cache_pkg::RD_BITS-1:0]                   rd,
	input  logic [cache_pkg::WARP_BITS-1:0]                 warp,

	// Core response, four-phase
	output logic                                            rsp_req,
	output logic [TID_BITS-1:0]                             rsp_tid,
	output logic [cache_pkg::WORD_BITS-1:0]                 rsp_data,
	output logic [cache_pkg::RD_BITS-1:0]                   rsp_rd,
	output logic [cache_pkg::WARP_BITS-1:0]                 rsp_warp,
	input  logic                                            rsp_ack
);

	import cache_pkg::*;

	// Accept to queue
	logic                                 push;
	logic                                 full;
	logic [NUM_LANES-1:0]                 push_lane_valid;
	logic [NUM_LANES-1:0]                 push_lane_op;
	logic [NUM_LANES-1:0][ADDR_BITS-1:0]  push_lane_addr;
	logic [NUM_LANES-1:0][WORD_BITS-1:0]  push_lane_wdata;
	logic [RD_BITS-1:0]                   push_rd;
	logic [WARP_BITS-1:0]                 push_warp;

	// Queue to bank
	logic                                 issue_valid;
	logic [TID_BITS-1:0]                  issue_tid;
	mem_op_t                              issue_op;
	logic [ADDR_BITS-1:0]                 issue_addr;
	logic [WORD_BITS-1:0]                 issue_wdata;
	logic [RD_BITS-1:0]                   issue_rd;
	logic [WARP_BITS-1:0]                 issue_warp;
	logic                                 issue_ready;

	// Bank to response buffer
	logic                                 load_valid;
	logic [TID_BITS-1:0]                  load_tid;
	logic [WORD_BITS-1:0]                 load_data;
	logic [RD_BITS-1:0]                   load_rd;
	logic [WARP_BITS-1:0]                 load_warp;
	logic                                 load_ready;

	core_req_accept #(
		.NUM_LANES (NUM_LANES)
	) u_accept (
		.clk             (clk),
		.reset           (reset),
		.core_req        (core_req),
		.core_ack        (core_ack),
		.lane_valid      (lane_valid),
		.lane_op         (lane_op),
		.lane_addr       (lane_addr),
		.lane_wdata      (lane_wdata),
		.rd              (rd),
		.warp            (warp),
		.full            (full),
		.push            (push),
		.push_lane_valid (push_lane_valid),
		.push_lane_op    (push_lane_op),
		.push_lane_addr  (push_lane_addr),
		.push_lane_wdata (push_lane_wdata),
		.push_rd         (push_rd),
		.push_warp       (push_warp)
	);

	cache_req_queue #(
		.NUM_LANES  (NUM_LANES),
		.REQQ_DEPTH (REQQ_DEPTH)
	) u_reqq (
		.clk         (clk),
		.reset       (reset),
		.push        (push),
		.lane_valid  (push_lane_valid),
		.lane_op     (push_lane_op),
		.lane_addr   (push_lane_addr),
		.lane_wdata  (push_lane_wdata),
		.rd          (push_rd),
		.warp        (push_warp),
		.full        (full),
		.issue_valid (issue_valid),
		.issue_tid   (issue_tid),
		.issue_op    (issue_op),
		.issue_addr  (issue_addr),
		.issue_wdata (issue_wdata),
		.issue_rd    (issue_rd),
		.issue_warp  (issue_warp),
		.issue_ready (issue_ready)
	);

	bank_data_store #(
		.BANK_WORDS (BANK_WORDS),
		.TID_BITS   (TID_BITS)
	) u_bank (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_tid   (issue_tid),
		.issue_op    (issue_op),
		.issue_addr  (issue_addr),
		.issue_wdata (issue_wdata),
		.issue_rd    (issue_rd),
		.issue_warp  (issue_warp),
		.issue_ready (issue_ready),
		.load_valid  (load_valid),
		.load_tid    (load_tid),
		.load_data   (load_data),
		.load_rd     (load_rd),
		.load_warp   (load_warp),
		.load_ready  (load_ready)
	);

	core_rsp_send #(
		.NUM_LANES (NUM_LANES)
	) u_rsp (
		.clk        (clk),
		.reset      (reset),
		.load_valid (load_valid),
		.load_tid   (load_tid),
		.load_data  (load_data),
		.load_rd    (load_rd),
		.load_warp  (load_warp),
		.load_ready (load_ready),
		.rsp_req    (rsp_req),
		.rsp_tid    (rsp_tid),
		.rsp_data   (rsp_data),
		.rsp_rd     (rsp_rd),
		.rsp_warp   (rsp_warp),
		.rsp_ack    (rsp_ack)
	);

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset drops on a rising edge like any other synchronous input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: tb/cache_bank_tb.sv
`timescale 1ns/1ps

module cache_bank_tb;

	import cache_pkg::*;

	localparam int NUM_LANES   = 4;
	localparam int TID_BITS    = 2;
	localparam int NUM_REQS    = 22;
	localparam int FIELDS      = 13;
	localparam int CLK_PERIOD  = 40;
	localparam int MODEL_WORDS = 64;

	logic                                 clk;
	logic                                 reset;
	logic                                 core_req;
	logic                                 core_ack;
	logic [NUM_LANES-1:0]                 lane_valid;
	logic [NUM_LANES-1:0]                 lane_op;
	logic [NUM_LANES-1:0][ADDR_BITS-1:0]  lane_addr;
	logic [NUM_LANES-1:0][WORD_BITS-1:0]  lane_wdata;
	logic [RD_BITS-1:0]                   rd;
	logic [WARP_BITS-1:0]                 warp;
	logic                                 rsp_req;
	logic [TID_BITS-1:0]                  rsp_tid;
	logic [WORD_BITS-1:0]                 rsp_data;
	logic [RD_BITS-1:0]                   rsp_rd;
	logic [WARP_BITS-1:0]                 rsp_warp;
	logic                                 rsp_ack;

	// One request per FIELDS words in file column order
	logic [31:0]          stim [NUM_REQS * FIELDS];
	logic [WORD_BITS-1:0] model_mem [MODEL_WORDS];
	logic [31:0]          lfsr;

	// Expected load responses with the oldest first
	int                   exp_req [$];
	int                   exp_tid [$];
	logic [WORD_BITS-1:0] exp_data [$];
	int                   exp_rd [$];
	int                   exp_warp [$];

	int load_count [NUM_REQS];
	int seen_count [NUM_REQS];
	int req_errors [NUM_REQS];
	bit acked [NUM_REQS];
	bit reported [NUM_REQS];
	int other_errors;
	int checks;
	int tests_failed;

	tb_clock_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (2)
	) clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	cache_bank_top #(
		.NUM_LANES  (NUM_LANES),
		.REQQ_DEPTH (4),
		.BANK_WORDS (MODEL_WORDS)
	) UUT (
		.clk        (clk),
		.reset      (reset),
		.core_req   (core_req),
		.core_ack   (core_ack),
		.lane_valid (lane_valid),
		.lane_op    (lane_op),
		.lane_addr  (lane_addr),
		.lane_wdata (lane_wdata),
		.rd         (rd),
		.warp       (warp),
		.rsp_req    (rsp_req),
		.rsp_tid    (rsp_tid),
		.rsp_data   (rsp_data),
		.rsp_rd     (rsp_rd),
		.rsp_warp   (rsp_warp),
		.rsp_ack    (rsp_ack)
	);

	// Right-shifting Galois LFSR with maximal length taps
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s >> 1;
		if (s[0]) begin
			lfsr_next = lfsr_next ^ 32'hA300_0000;
		end
	endfunction

	// Five bits give 0 to 31 cycles
	task automatic random_delay(output int cycles);
		cycles = 0;
		for (int b = 0; b < 5; b++) begin
			cycles = (cycles << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Lanes in ascending order so stores land before later lanes read
	task automatic apply_model(input int r);
		int base;
		int idx;
		base = r * FIELDS;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (stim[base][l]) begin
				idx = stim[base + 2 + l] % MODEL_WORDS;
				if (stim[base + 1][l]) begin
					model_mem[idx] = stim[base + 6 + l];
				end else begin
					exp_req.push_back(r);
					exp_tid.push_back(l);
					exp_data.push_back(model_mem[idx]);
					exp_rd.push_back(stim[base + 10]);
					exp_warp.push_back(stim[base + 11]);
					load_count[r]++;
				end
			end
		end
	endtask

	task automatic report_if_done(input int r);
		if (acked[r] && !reported[r] && seen_count[r] == load_count[r]) begin
			reported[r] = 1'b1;
			if (req_errors[r] == 0) begin
				$display("request %0d ok, %0d load responses", r, seen_count[r]);
			end else begin
				tests_failed++;
				$display("request %0d failed with %0d errors", r, req_errors[r]);
			end
		end
	endtask

	task automatic send_request(input int r);
		int                                  base;
		logic [NUM_LANES-1:0][ADDR_BITS-1:0] addr_v;
		logic [NUM_LANES-1:0][WORD_BITS-1:0] wdata_v;
		base = r * FIELDS;
		for (int l = 0; l < NUM_LANES; l++) begin
			addr_v[l]  = stim[base + 2 + l];
			wdata_v[l] = stim[base + 6 + l];
		end
		@(posedge clk);
		lane_valid <= stim[base][NUM_LANES-1:0];
		lane_op    <= stim[base + 1][NUM_LANES-1:0];
		lane_addr  <= addr_v;
		lane_wdata <= wdata_v;
		rd         <= stim[base + 10][RD_BITS-1:0];
		warp       <= stim[base + 11][WARP_BITS-1:0];
		core_req   <= 1'b1;
		do @(negedge clk); while (!core_ack);
		@(posedge clk);
		core_req <= 1'b0;
		do @(negedge clk); while (core_ack);
	endtask

	initial begin : main
		int total_errors;
		core_req     = 1'b0;
		lane_valid   = '0;
		lane_op      = '0;
		lane_addr    = '0;
		lane_wdata   = '0;
		rd           = '0;
		warp         = '0;
		rsp_ack      = 1'b0;
		lfsr         = 32'h5335_96bb;
		other_errors = 0;
		checks       = 0;
		tests_failed = 0;
		$readmemh("tb/cache_testdata.txt", stim);
		if ($isunknown(stim[NUM_REQS * FIELDS - 1])) begin
			$display("testdata file is missing or holds fewer than %0d requests", NUM_REQS);
			other_errors++;
		end else begin
			@(negedge clk);
			while (reset) @(negedge clk);
			for (int r = 0; r < NUM_REQS; r++) begin
				apply_model(r);
				send_request(r);
				acked[r] = 1'b1;
				report_if_done(r);
			end
			while (exp_req.size() != 0 || rsp_req || rsp_ack) @(negedge clk);
			// Any stray response shows up in this quiet period
			repeat (20) @(negedge clk);
			for (int r = 0; r < NUM_REQS; r++) begin
				if (!reported[r]) begin
					$display("request %0d never completed", r);
					other_errors++;
				end
			end
		end
		total_errors = other_errors;
		for (int r = 0; r < NUM_REQS; r++) begin
			total_errors += req_errors[r];
		end
		$display("summary: %0d requests, %0d failed, %0d responses checked, %0d errors",
			NUM_REQS, tests_failed, checks, total_errors);
		if (total_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin : responder
		int                   r;
		int                   delay;
		logic [TID_BITS-1:0]  e_tid;
		logic [WORD_BITS-1:0] e_data;
		logic [RD_BITS-1:0]   e_rd;
		logic [WARP_BITS-1:0] e_warp;
		@(negedge clk);
		while (reset) @(negedge clk);
		forever begin
			@(negedge clk);
			if (rsp_req) begin
				delay = 0;
				if (exp_req.size() == 0) begin
					$display("a response arrived with no load outstanding");
					other_errors++;
				end else begin
					r      = exp_req.pop_front();
					e_tid  = exp_tid.pop_front();
					e_data = exp_data.pop_front();
					e_rd   = exp_rd.pop_front();
					e_warp = exp_warp.pop_front();
					checks++;
					if (rsp_tid !== e_tid) begin
						$display("FAIL request %0d rsp_tid: got %h expected %h",
							r, rsp_tid, e_tid);
						req_errors[r]++;
					end
					if (rsp_data !== e_data) begin
						$display("FAIL request %0d rsp_data: got %h expected %h",
							r, rsp_data, e_data);
						req_errors[r]++;
					end
					if (rsp_rd !== e_rd) begin
						$display("FAIL request %0d rsp_rd: got %h expected %h",
							r, rsp_rd, e_rd);
						req_errors[r]++;
					end
					if (rsp_warp !== e_warp) begin
						$display("FAIL request %0d rsp_warp: got %h expected %h",
							r, rsp_warp, e_warp);
						req_errors[r]++;
					end
					seen_count[r]++;
					report_if_done(r);
					if (stim[r * FIELDS + 12] == 32'hFF) begin
						random_delay(delay);
					end else begin
						delay = stim[r * FIELDS + 12];
					end
				end
				repeat (delay) @(posedge clk);
				@(posedge clk);
				rsp_ack <= 1'b1;
				do @(negedge clk); while (rsp_req);
				// Keep rsp_ack high just as long after rsp_req drops
				repeat (delay) @(posedge clk);
				@(posedge clk);
				rsp_ack <= 1'b0;
			end
		end
	end

	// Four-phase rules on both sides
	initial begin : protocol_monitor
		logic prev_core_ack;
		logic prev_rsp_req;
		@(negedge clk);
		while (reset) @(negedge clk);
		if (core_ack !== 1'b0) begin
			$display("FAIL core_ack after reset: got %h expected 0", core_ack);
			other_errors++;
		end
		if (rsp_req !== 1'b0) begin
			$display("FAIL rsp_req after reset: got %h expected 0", rsp_req);
			other_errors++;
		end
		prev_core_ack = core_ack;
		prev_rsp_req  = rsp_req;
		forever begin
			@(negedge clk);
			if (core_ack && !prev_core_ack && !core_req) begin
				$display("core_ack rose while core_req was low");
				other_errors++;
			end
			if (rsp_req && !prev_rsp_req && rsp_ack) begin
				$display("rsp_req rose while rsp_ack was still high");
				other_errors++;
			end
			prev_core_ack = core_ack;
			prev_rsp_req  = rsp_req;
		end
	end

	// Room for 200 cycles per request
	initial begin : watchdog
		#(NUM_REQS * 200 * CLK_PERIOD);
		$display("timeout, the run did not finish within %0d cycles", NUM_REQS * 200);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: tb/cache_testdata.txt
// vld op addr0 addr1 addr2 addr3 wdata0 wdata1 wdata2 wdata3 rd warp dly
// op bit set = store for that lane; dly = cycles before rsp_ack, FF = random
// Addresses wrap modulo 64 in the bank
F F 00000000 00000001 00000002 00000003 11111111 22222222 33333333 44444444 01 1 00
F 0 00000040 00000041 00000042 00000043 00000000 00000000 00000000 00000000 02 2 00
F F 00000100 00000005 00000006 00000007 A5A5A5A5 55555555 66666666 77777777 03 3 01
F 0 00000000 00000005 FFFFFFC6 00000047 00000000 00000000 00000000 00000000 04 4 02
A 0 00000003 00000001 00000002 00000003 00000000 00000000 00000000 00000000 1F F 03
D 4 00000002 00000009 00000008 00000001 00000000 00000000 88888888 00000000 0A 5 00
F 9 0000000A 0000004A 00000008 00000008 CAFE0001 00000000 00000000 BEEF0003 0C 6 01
F 0 0000000A 00000008 00000048 0000008A 00000000 00000000 00000000 00000000 0D 7 00
0 F 00000000 00000001 00000002 00000003 DEADDEAD DEADDEAD DEADDEAD DEADDEAD 10 8 00
1 0 00000000 00000001 00000002 00000003 00000000 00000000 00000000 00000000 11 9 00
F 0 00000001 00000002 00000003 00000005 00000000 00000000 00000000 00000000 12 A 20
F 0 00000006 00000007 00000008 0000000A 00000000 00000000 00000000 00000000 13 B FF
F 2 00000000 0000000C 00000001 0000000C 00000000 12345678 00000000 00000000 14 C FF
F 0 0000000C 0000004C 0000008C 000000CC 00000000 00000000 00000000 00000000 15 D 18
5 0 00000002 00000000 00000003 00000000 00000000 00000000 00000000 00000000 16 E FF
F 0 00000005 00000006 00000007 00000008 00000000 00000000 00000000 00000000 17 F FF
3 1 0000000D 0000000D 00000000 00000000 0F0F0F0F 00000000 00000000 00000000 18 0 10
F 0 0000000D 00000000 0000000A 0000000C 00000000 00000000 00000000 00000000 19 1 FF
0 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1A 2 00
F F 00000010 00000011 00000012 00000013 0000AAAA 0000BBBB 0000CCCC 0000DDDD 1B 3 00
F 0 00000013 00000012 00000011 00000010 00000000 00000000 00000000 00000000 1C 4 FF
8 0 00000000 00000000 00000000 00000050 00000000 00000000 00000000 00000000 1D 5 05

// File: vlog.f
source/cache_pkg.sv
source/req_fifo.sv
source/core_req_accept.sv
source/cache_req_queue.sv
source/bank_data_store.sv
source/core_rsp_send.sv
source/cache_bank_top.sv
tb/tb_clock_gen.sv
tb/cache_bank_tb.sv
